// ==== icache_pkg.sv ====
package icache_pkg;

    // cache geometry
    localparam int LEN_LINE = 5;
    localparam int LEN_INDEX = 7;
    localparam int LEN_TAG = 32 - LEN_LINE - LEN_INDEX;
    localparam int LEN_WORD_SEL = LEN_LINE - 2;
    localparam int NR_WORDS = 1 << LEN_WORD_SEL;
    localparam int NR_SETS = 1 << LEN_INDEX;
    localparam int NR_WAYS = 2;
    localparam int LEN_DATA_ADDR = LEN_INDEX + LEN_WORD_SEL;

    // AR channel constants
    localparam logic [2:0] AXI_SIZE_WORD = 3'd2;
    localparam logic [7:0] AXI_LEN_LINE = 8'(NR_WORDS - 1);

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [LEN_TAG-1:0] tag_t;
    typedef logic [LEN_INDEX-1:0] index_t;
    typedef logic [LEN_WORD_SEL-1:0] word_sel_t;
    typedef logic [NR_WAYS-1:0] way_bits_t;

    // one fetch as it moves down IF1, IF2, IF3
    typedef struct packed {
        tag_t      tag;
        index_t    index;
        word_sel_t word_sel;
        logic      no_cache;
        logic      en;
    } fetch_req_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_UNCACHED
    } ctrl_state_t;

endpackage

// ==== sdp_ram.sv ====
`timescale 1ns/1ns

module sdp_ram #(
    parameter int LEN_DATA = 32,
    parameter int LEN_ADDR = 10
) (
    input  logic                clk,
    // write port
    input  logic                i_wea,
    input  logic [LEN_ADDR-1:0] i_addra,
    input  logic [LEN_DATA-1:0] i_dina,
    // read port
    input  logic                i_enb,
    input  logic [LEN_ADDR-1:0] i_addrb,
    output logic [LEN_DATA-1:0] o_doutb
);

    (* ram_style = "block" *) logic [LEN_DATA-1:0] mem [1 << LEN_ADDR];

    always_ff @(posedge clk) begin
        if (i_wea) begin
            mem[i_addra] <= i_dina;
        end
    end

    // output holds while the read enable is low
    always_ff @(posedge clk) begin
        if (i_enb) begin
            o_doutb <= mem[i_addrb];
        end
    end

endmodule

// ==== icache_meta.sv ====
`timescale 1ns/1ns

module icache_meta
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_rd_en,
    input  index_t    i_rd_index,
    output way_bits_t o_valid,
    output way_bits_t o_lru,
    input  logic      i_hit_upd,
    input  logic      i_fill_upd,
    input  index_t    i_upd_index,
    input  logic      i_upd_way
);

    way_bits_t valid_q [NR_SETS];
    way_bits_t lru_q [NR_SETS];
    logic      upd;
    way_bits_t new_valid;
    way_bits_t new_lru;

    assign upd = i_hit_upd | i_fill_upd;

    // named way becomes recent and the other one old
    always_comb begin
        new_lru = i_upd_way ? 2'b01 : 2'b10;
        new_valid = valid_q[i_upd_index];
        if (i_fill_upd) begin
            new_valid[i_upd_way] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NR_SETS; i++) begin
                valid_q[i] <= '0;
                lru_q[i] <= '0;
            end
        end else if (upd) begin
            valid_q[i_upd_index] <= new_valid;
            lru_q[i_upd_index] <= new_lru;
        end
    end

    // a hit update in IF2 may target the set being read for IF1
    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= '0;
            o_lru <= '0;
        end else if (i_rd_en) begin
            if (upd && i_upd_index == i_rd_index) begin
                o_valid <= new_valid;
                o_lru <= new_lru;
            end else begin
                o_valid <= valid_q[i_rd_index];
                o_lru <= lru_q[i_rd_index];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(i_hit_upd && i_fill_upd));

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl
    import icache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // core side
    input  addr_t     i_cpu_inst_addr,
    input  logic      i_cpu_inst_en,
    input  logic      i_no_cache,
    input  logic      i_icache_ctl,
    output word_t     o_cpu_inst_rdata,
    output logic      o_stall,
    // AXI read address
    output addr_t     o_araddr,
    output logic [7:0] o_arlen,
    output logic [2:0] o_arsize,
    output logic      o_arvalid,
    input  logic      i_arready,
    // AXI read data
    input  word_t     i_rdata,
    input  logic      i_rvalid,
    input  logic      i_rlast,
    output logic      o_rready,
    // lookup
    output logic      o_rd_en,
    output index_t    o_rd_index,
    output word_sel_t o_rd_word,
    input  way_bits_t i_valid,
    input  way_bits_t i_lru,
    input  tag_t      i_tag0,
    input  tag_t      i_tag1,
    input  word_t     i_word0,
    input  word_t     i_word1,
    // array writes and metadata updates
    output way_bits_t o_tag_we,
    output way_bits_t o_data_we,
    output index_t    o_wr_index,
    output word_sel_t o_wr_word,
    output tag_t      o_wr_tag,
    output logic      o_hit_upd,
    output logic      o_fill_upd,
    output logic      o_upd_way
);

    fetch_req_t  req_if1;
    fetch_req_t  req_if2;
    fetch_req_t  req_if3;
    ctrl_state_t state;
    way_bits_t   hit_way;
    way_bits_t   victim_mask;
    logic        hit;
    logic        advance;
    logic        done;
    logic        victim;
    logic        beat;
    logic        fill;
    word_sel_t   beat_cnt;
    word_t       captured;

    // IF1 fields straight off the fetch address
    always_comb begin
        req_if1.tag = i_cpu_inst_addr[31 -: LEN_TAG];
        req_if1.index = i_cpu_inst_addr[LEN_LINE +: LEN_INDEX];
        req_if1.word_sel = i_cpu_inst_addr[2 +: LEN_WORD_SEL];
        req_if1.no_cache = i_no_cache;
        req_if1.en = i_cpu_inst_en;
    end

    assign advance = ~o_stall & ~i_icache_ctl;
    assign o_rd_en = advance;
    assign o_rd_index = req_if1.index;
    assign o_rd_word = req_if1.word_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_if2 <= '0;
        end else if (advance) begin
            req_if2 <= req_if1;
        end
    end

    // IF2 tag compare
    assign hit_way[0] = i_valid[0] & (i_tag0 == req_if2.tag);
    assign hit_way[1] = i_valid[1] & (i_tag1 == req_if2.tag);
    assign hit = req_if2.en & ~req_if2.no_cache & (|hit_way);

    assign o_stall = (state != ST_IDLE) | (req_if2.en & ~done & ~hit);
    assign o_cpu_inst_rdata = done ? captured : (hit_way[1] ? i_word1 : i_word0);

    assign beat = o_rready & i_rvalid;
    assign fill = (state == ST_REFILL) & beat & i_rlast;
    assign victim_mask = victim ? 2'b10 : 2'b01;

    assign o_data_we = ((state == ST_REFILL) && beat) ? victim_mask : 2'b00;
    assign o_tag_we = fill ? victim_mask : 2'b00;
    assign o_wr_index = (state == ST_IDLE) ? req_if2.index : req_if3.index;
    assign o_wr_word = beat_cnt;
    assign o_wr_tag = req_if3.tag;
    assign o_arsize = AXI_SIZE_WORD;

    assign o_hit_upd = hit & ~done & (state == ST_IDLE);
    assign o_fill_upd = fill;
    assign o_upd_way = fill ? victim : hit_way[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            done <= 1'b0;
            o_arvalid <= 1'b0;
            o_rready <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (advance) begin
                done <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (req_if2.en && !done && !hit) begin
                        req_if3 <= req_if2;
                        o_arvalid <= 1'b1;
                        beat_cnt <= '0;
                        if (req_if2.no_cache) begin
                            o_araddr <= {req_if2.tag, req_if2.index, req_if2.word_sel, 2'b00};
                            o_arlen <= 8'd0;
                            state <= ST_UNCACHED;
                        end else begin
                            // refill from the line base into the least recent way
                            o_araddr <= {req_if2.tag, req_if2.index, {LEN_LINE{1'b0}}};
                            o_arlen <= AXI_LEN_LINE;
                            victim <= i_lru[1];
                            state <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL, ST_UNCACHED: begin
                    if (o_arvalid) begin
                        if (i_arready) begin
                            o_arvalid <= 1'b0;
                            o_rready <= 1'b1;
                        end
                    end else if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        // requested word passes by
                        if (state == ST_UNCACHED || beat_cnt == req_if3.word_sel) begin
                            captured <= i_rdata;
                        end
                        if (i_rlast) begin
                            o_rready <= 1'b0;
                            done <= 1'b1;
                            state <= ST_IDLE;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

    assert property (@(posedge clk) disable iff (rst) state == ST_IDLE |-> !o_rready);

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ns

module icache_top
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  addr_t      i_cpu_inst_addr,
    input  logic       i_cpu_inst_en,
    input  logic       i_no_cache,
    input  logic       i_icache_ctl,
    output word_t      o_cpu_inst_rdata,
    output logic       o_stall,
    output addr_t      o_araddr,
    output logic [7:0] o_arlen,
    output logic [2:0] o_arsize,
    output logic       o_arvalid,
    input  logic       i_arready,
    input  word_t      i_rdata,
    input  logic       i_rvalid,
    input  logic       i_rlast,
    output logic       o_rready
);

    logic      rd_en;
    index_t    rd_index;
    word_sel_t rd_word;
    way_bits_t valid;
    way_bits_t lru;
    tag_t      tag_rd [NR_WAYS];
    word_t     word_rd [NR_WAYS];
    way_bits_t tag_we;
    way_bits_t data_we;
    index_t    wr_index;
    word_sel_t wr_word;
    tag_t      wr_tag;
    logic      hit_upd;
    logic      fill_upd;
    logic      upd_way;

    icache_ctrl ctrl_i (
        .clk, .rst,
        .i_cpu_inst_addr, .i_cpu_inst_en, .i_no_cache, .i_icache_ctl,
        .o_cpu_inst_rdata, .o_stall,
        .o_araddr, .o_arlen, .o_arsize, .o_arvalid, .i_arready,
        .i_rdata, .i_rvalid, .i_rlast, .o_rready,
        .o_rd_en(rd_en), .o_rd_index(rd_index), .o_rd_word(rd_word),
        .i_valid(valid), .i_lru(lru),
        .i_tag0(tag_rd[0]), .i_tag1(tag_rd[1]),
        .i_word0(word_rd[0]), .i_word1(word_rd[1]),
        .o_tag_we(tag_we), .o_data_we(data_we),
        .o_wr_index(wr_index), .o_wr_word(wr_word), .o_wr_tag(wr_tag),
        .o_hit_upd(hit_upd), .o_fill_upd(fill_upd), .o_upd_way(upd_way)
    );

    icache_meta meta_i (
        .clk, .rst,
        .i_rd_en(rd_en), .i_rd_index(rd_index),
        .o_valid(valid), .o_lru(lru),
        .i_hit_upd(hit_upd), .i_fill_upd(fill_upd),
        .i_upd_index(wr_index), .i_upd_way(upd_way)
    );

    // one tag RAM and one data RAM per way
    for (genvar w = 0; w < NR_WAYS; w++) begin : g_way
        sdp_ram #(.LEN_DATA(LEN_TAG), .LEN_ADDR(LEN_INDEX)) tag_ram_i (
            .clk,
            .i_wea(tag_we[w]), .i_addra(wr_index), .i_dina(wr_tag),
            .i_enb(rd_en), .i_addrb(rd_index), .o_doutb(tag_rd[w])
        );
        sdp_ram #(.LEN_DATA(32), .LEN_ADDR(LEN_DATA_ADDR)) data_ram_i (
            .clk,
            .i_wea(data_we[w]), .i_addra({wr_index, wr_word}), .i_dina(i_rdata),
            .i_enb(rd_en), .i_addrb({rd_index, rd_word}), .o_doutb(word_rd[w])
        );
    end

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ns

module tb_axi_mem
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  addr_t       i_araddr,
    input  logic [7:0]  i_arlen,
    input  logic [2:0]  i_arsize,
    input  logic        i_arvalid,
    output logic        o_arready,
    output word_t       o_rdata,
    output logic        o_rvalid,
    output logic        o_rlast,
    input  logic        i_rready,
    input  logic [31:0] i_rnd,
    output addr_t       o_beat_addr,
    input  word_t       i_beat_data,
    output int          o_line_bursts,
    output int          o_single_bursts,
    output int          o_errors
);

    logic       busy;
    logic [7:0] beats_left;
    logic       ar_fire;
    logic       r_fire;
    addr_t      ar_addr;
    logic [7:0] ar_len;
    logic [2:0] ar_size;

    // data for the current beat comes from the testbench top
    assign o_rdata = i_beat_data;

    initial begin
        o_arready = 1'b0;
        o_rvalid = 1'b0;
        o_rlast = 1'b0;
        o_beat_addr = '0;
        o_line_bursts = 0;
        o_single_bursts = 0;
        o_errors = 0;
        busy = 1'b0;
        beats_left = '0;
    end

    always @(posedge clk) begin
        ar_fire = i_arvalid && o_arready;
        r_fire = o_rvalid && i_rready;
        ar_addr = i_araddr;
        ar_len = i_arlen;
        ar_size = i_arsize;
        #1;
        if (rst) begin
            busy = 1'b0;
            o_arready = 1'b0;
            o_rvalid = 1'b0;
            o_rlast = 1'b0;
        end else begin
            if (ar_fire) begin
                if (ar_size != AXI_SIZE_WORD) begin
                    $display("ERROR o_arsize: got %h expected %h", ar_size, AXI_SIZE_WORD);
                    o_errors++;
                end
                if (ar_len == AXI_LEN_LINE) begin
                    o_line_bursts++;
                    if (ar_addr[LEN_LINE-1:0] != '0) begin
                        $display("ERROR o_araddr: got %h expected %h", ar_addr,
                                 {ar_addr[31:LEN_LINE], {LEN_LINE{1'b0}}});
                        o_errors++;
                    end
                end else if (ar_len == 8'd0) begin
                    o_single_bursts++;
                end else begin
                    $display("ERROR o_arlen: got %h expected %h", ar_len, AXI_LEN_LINE);
                    o_errors++;
                end
                busy = 1'b1;
                beats_left = ar_len;
                o_beat_addr = ar_addr;
            end else if (r_fire) begin
                if (o_rlast) begin
                    busy = 1'b0;
                end else begin
                    beats_left = beats_left - 8'd1;
                    o_beat_addr = o_beat_addr + 32'd4;
                end
            end
            // valid stays up until the beat is taken
            if (!busy) begin
                o_rvalid = 1'b0;
            end else if (!o_rvalid || r_fire) begin
                o_rvalid = i_rnd[19:18] != 2'b00;
            end
            o_rlast = busy && beats_left == 8'd0;
            o_arready = !busy && i_rnd[17:16] != 2'b00;
        end
    end

endmodule

// ==== tb_icache_top.sv ====
`timescale 1ns/1ns

module tb_icache_top
    import icache_pkg::*;
();

    logic        clk;
    logic        rst;
    addr_t       cpu_addr;
    logic        cpu_en;
    logic        no_cache;
    logic        icache_ctl;
    word_t       rdata;
    logic        stall;
    addr_t       araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic        arvalid;
    logic        arready;
    word_t       axi_rdata;
    logic        rvalid;
    logic        rlast;
    logic        rready;
    addr_t       beat_addr;
    word_t       beat_data;
    logic [31:0] bus_rnd;
    logic        freeze_on;
    int          line_bursts;
    int          single_bursts;
    int          mem_errors;
    int          errors;
    int          mark;
    int          ntests;
    int          nfailed;
    // m_old names the way the LRU model evicts next
    tag_t        m_tag [NR_SETS][NR_WAYS];
    logic        m_valid [NR_SETS][NR_WAYS];
    logic        m_old [NR_SETS];

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // fixed scramble of the word address
    function automatic word_t mem_word(input addr_t a);
        word_t w;
        w = {a[31:2], 2'b00};
        w = w ^ {w[15:0], w[31:16]} ^ 32'h9e3779b9;
        return (w * 32'd2654435761) ^ (w >> 7);
    endfunction

    // true when a line refill is expected
    function automatic logic predict_refill(input addr_t a, input logic nc);
        index_t idx;
        tag_t   t;
        logic   miss;
        idx = a[LEN_LINE +: LEN_INDEX];
        t = a[31 -: LEN_TAG];
        miss = !nc;
        if (!nc) begin
            for (int w = 0; w < NR_WAYS; w++) begin
                if (m_valid[idx][w] && m_tag[idx][w] == t) begin
                    miss = 1'b0;
                    m_old[idx] = (w == 0);
                end
            end
        end
        if (miss) begin
            m_valid[idx][m_old[idx]] = 1'b1;
            m_tag[idx][m_old[idx]] = t;
            m_old[idx] = !m_old[idx];
        end
        return miss;
    endfunction

    task automatic clear_model();
        for (int s = 0; s < NR_SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_old[s] = 1'b0;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after 200 cycles: %s", what);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        if (arvalid !== 1'b0 || rready !== 1'b0 || stall !== 1'b0) begin
            $display("ERROR reset: o_arvalid %h o_rready %h o_stall %h expected 0",
                     arvalid, rready, stall);
            errors++;
        end
        rst = 1'b0;
    endtask

    // called and returns 1 ns after a rising edge
    task automatic fetch(input addr_t a, input logic nc);
        word_t exp;
        logic  miss;
        int    lines0;
        int    singles0;
        int    t;
        exp = mem_word(a);
        miss = predict_refill(a, nc);
        lines0 = line_bursts;
        singles0 = single_bursts;
        cpu_addr = a;
        cpu_en = 1'b1;
        no_cache = nc;
        // IF1 moves on at an edge with no stall and no freeze
        t = 0;
        @(negedge clk);
        while (stall || icache_ctl) begin
            t++;
            if (t > 200) begin
                report_timeout("fetch never left IF1");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cpu_en = 1'b0;
        t = 0;
        @(negedge clk);
        while (stall) begin
            t++;
            if (t > 200) begin
                report_timeout("o_stall stuck high");
            end
            @(negedge clk);
        end
        if (rdata !== exp) begin
            $display("ERROR o_cpu_inst_rdata: addr %h got %h expected %h", a, rdata, exp);
            errors++;
        end
        if (!miss && !nc && t != 0) begin
            $display("ERROR o_stall: addr %h got 1 expected 0 on a hit", a);
            errors++;
        end
        @(posedge clk);
        #1;
        if (line_bursts - lines0 != int'(miss)) begin
            $display("ERROR line bursts: addr %h got %0h expected %0h",
                     a, line_bursts - lines0, miss);
            errors++;
        end
        if (single_bursts - singles0 != int'(nc)) begin
            $display("ERROR single bursts: addr %h got %0h expected %0h",
                     a, single_bursts - singles0, nc);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors + mem_errors - mark;
        ntests++;
        if (n != 0) begin
            nfailed++;
        end
        $display("test %0d %s: %s, %0d errors", ntests, name, n == 0 ? "ok" : "failed", n);
        mark = errors + mem_errors;
    endtask

    icache_top dut_i (
        .clk, .rst,
        .i_cpu_inst_addr(cpu_addr), .i_cpu_inst_en(cpu_en),
        .i_no_cache(no_cache), .i_icache_ctl(icache_ctl),
        .o_cpu_inst_rdata(rdata), .o_stall(stall),
        .o_araddr(araddr), .o_arlen(arlen), .o_arsize(arsize),
        .o_arvalid(arvalid), .i_arready(arready),
        .i_rdata(axi_rdata), .i_rvalid(rvalid), .i_rlast(rlast), .o_rready(rready)
    );

    tb_axi_mem mem_i (
        .clk, .rst,
        .i_araddr(araddr), .i_arlen(arlen), .i_arsize(arsize),
        .i_arvalid(arvalid), .o_arready(arready),
        .o_rdata(axi_rdata), .o_rvalid(rvalid), .o_rlast(rlast), .i_rready(rready),
        .i_rnd(bus_rnd), .o_beat_addr(beat_addr), .i_beat_data(beat_data),
        .o_line_bursts(line_bursts), .o_single_bursts(single_bursts),
        .o_errors(mem_errors)
    );

    assign beat_data = mem_word(beat_addr);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        bus_rnd <= lcg_next(bus_rnd);
    end

    // random freeze pulses from the core
    always @(posedge clk) begin
        #1;
        icache_ctl = freeze_on && bus_rnd[21:20] == 2'b00;
    end

    initial begin
        logic [31:0] stim;
        addr_t       a;
        int          t;
        clk = 1'b0;
        rst = 1'b1;
        cpu_addr = '0;
        cpu_en = 1'b0;
        no_cache = 1'b0;
        icache_ctl = 1'b0;
        freeze_on = 1'b0;
        bus_rnd = 32'h5285;
        stim = 32'h5285;
        errors = 0;
        mark = 0;
        ntests = 0;
        nfailed = 0;
        clear_model();
        apply_reset();

        fetch(32'h0000_1234, 1'b0);
        end_test("cold miss");

        for (int i = 0; i < NR_WORDS; i++) begin
            if (i != 5) begin
                fetch(32'h0000_1220 + 32'(4 * i), 1'b0);
            end
        end
        end_test("hit");

        fetch(32'h0000_2468, 1'b1);
        fetch(32'h0000_2468, 1'b0);
        end_test("uncached");

        // three tags in one set
        fetch(32'h0001_0040, 1'b0);
        fetch(32'h0002_0044, 1'b0);
        fetch(32'h0001_0048, 1'b0);
        fetch(32'h0003_004c, 1'b0);
        fetch(32'h0001_0050, 1'b0);
        fetch(32'h0002_0054, 1'b0);
        end_test("lru");

        freeze_on = 1'b1;
        for (int i = 0; i < 200; i++) begin
            stim = lcg_next(stim);
            a = (addr_t'(stim[21:20]) << 16) | (addr_t'(stim[24]) << 6);
            a = a | (addr_t'(stim[27:25]) << 2);
            fetch(a, stim[30:28] == 3'd0);
        end
        freeze_on = 1'b0;
        end_test("random with freeze");

        fetch(32'h0000_1234, 1'b0);
        // reset lands in the middle of a refill
        cpu_addr = 32'h0000_5678;
        cpu_en = 1'b1;
        no_cache = 1'b0;
        t = 0;
        @(negedge clk);
        while (!rready) begin
            t++;
            if (t > 200) begin
                report_timeout("refill never started");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cpu_en = 1'b0;
        apply_reset();
        clear_model();
        fetch(32'h0000_1234, 1'b0);
        end_test("reset");

        $display("tests %0d, failed %0d, errors %0d", ntests, nfailed, errors + mem_errors);
        if (errors + mem_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== src.f ====
icache_pkg.sv
sdp_ram.sv
icache_meta.sv
icache_ctrl.sv
icache_top.sv
tb_axi_mem.sv
tb_icache_top.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - icache_pkg.sv
      - sdp_ram.sv
      - icache_meta.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    files:
      - tb_axi_mem.sv
      - tb_icache_top.sv
